// ==== hw/fwrisc_consts.svh ====
// Reset vector, register count, major opcodes and funct3 codes
`ifndef FWRISC_CONSTS_SVH
`define FWRISC_CONSTS_SVH

`define FWRISC_RESET_VECTOR 32'h8000_0000
`define FWRISC_NUM_REGS     32

// Major opcodes in instr[6:0]
`define FWRISC_OPC_OP       7'b0110011
`define FWRISC_OPC_OP_IMM   7'b0010011
`define FWRISC_OPC_LOAD     7'b0000011
`define FWRISC_OPC_STORE    7'b0100011
`define FWRISC_OPC_BRANCH   7'b1100011
`define FWRISC_OPC_JAL      7'b1101111
`define FWRISC_OPC_JALR     7'b1100111
`define FWRISC_OPC_LUI      7'b0110111
`define FWRISC_OPC_AUIPC    7'b0010111

// Arithmetic funct3
`define FWRISC_F3_ADD       3'b000
`define FWRISC_F3_SLL       3'b001
`define FWRISC_F3_SLT       3'b010
`define FWRISC_F3_SLTU      3'b011
`define FWRISC_F3_XOR       3'b100
`define FWRISC_F3_SR        3'b101 // SRL or SRA by instr[30]
`define FWRISC_F3_OR        3'b110
`define FWRISC_F3_AND       3'b111

// Store widths
`define FWRISC_F3_SB        3'b000
`define FWRISC_F3_SH        3'b001
`define FWRISC_F3_SW        3'b010

`endif

// ==== hw/fwrisc_pkg.sv ====
// Word, PC, register-address and instruction types plus state, ALU and compare enums
package fwrisc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [29:0] pc_t;       // Word address, low two bits implied zero
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  strb_t;     // One bit per byte lane

	// Multi-cycle sequence
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMR,
		MEMW
	} state_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // LUI and branch target
	} alu_op_e;

	typedef enum logic [1:0] {
		CMP_EQ,
		CMP_LT,    // Signed
		CMP_LTU
	} cmp_op_e;

endpackage

// ==== hw/fwrisc_decode.sv ====
// Instruction decoder with class flags, immediates, operand and operation select
`timescale 1ns/1ps
`include "fwrisc_consts.svh"

module fwrisc_decode (
	input  fwrisc_pkg::instr_t  instr,
	input  fwrisc_pkg::pc_t     pc,
	input  fwrisc_pkg::word_t   ra_rdata,
	input  fwrisc_pkg::word_t   rb_rdata,
	output logic                op_ld,
	output logic                op_st,
	output logic                op_branch,
	output logic                op_jal,
	output logic                op_jalr,
	output fwrisc_pkg::word_t   alu_op_a,
	output fwrisc_pkg::word_t   alu_op_b,
	output fwrisc_pkg::alu_op_e alu_op,
	output fwrisc_pkg::cmp_op_e cmp_op,
	output fwrisc_pkg::word_t   cmp_b,
	output logic                cmp_negate,
	output logic                set_less
);
	import fwrisc_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       op_arith_reg;
	logic       op_arith_imm;
	logic       op_lui;
	logic       op_auipc;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	word_t      pc_word;
	word_t      branch_target;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	// Class flags, FENCE and unknown opcodes match none
	assign op_ld        = (opcode == `FWRISC_OPC_LOAD);   // Treated as LW
	assign op_st        = (opcode == `FWRISC_OPC_STORE);
	assign op_branch    = (opcode == `FWRISC_OPC_BRANCH);
	assign op_jal       = (opcode == `FWRISC_OPC_JAL);
	assign op_jalr      = (opcode == `FWRISC_OPC_JALR);
	assign op_arith_reg = (opcode == `FWRISC_OPC_OP);
	assign op_arith_imm = (opcode == `FWRISC_OPC_OP_IMM);
	assign op_lui       = (opcode == `FWRISC_OPC_LUI);
	assign op_auipc     = (opcode == `FWRISC_OPC_AUIPC);

	// Sign-extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign pc_word = {pc, 2'b00};
	// Branch target added here so the ALU comparator keeps rs1 and rs2
	assign branch_target = pc_word + imm_b;

	always_comb begin
		alu_op_a = '0;
		alu_op_b = '0;
		alu_op   = ALU_ADD;
		if (op_lui) begin
			alu_op_b = imm_u;
			alu_op   = ALU_PASS_B;
		end else if (op_auipc) begin
			alu_op_a = pc_word;
			alu_op_b = imm_u;
		end else if (op_jal) begin
			alu_op_a = pc_word;
			alu_op_b = imm_j;
		end else if (op_jalr) begin
			alu_op_a = ra_rdata;
			alu_op_b = imm_i; // Bit 0 dropped with the PC's low bits
		end else if (op_branch) begin
			alu_op_a = ra_rdata;      // Compared against rs2
			alu_op_b = branch_target;
			alu_op   = ALU_PASS_B;
		end else if (op_ld) begin
			alu_op_a = ra_rdata;
			alu_op_b = imm_i;
		end else if (op_st) begin
			alu_op_a = ra_rdata;
			alu_op_b = imm_s;
		end else if (op_arith_imm || op_arith_reg) begin
			alu_op_a = ra_rdata;
			alu_op_b = op_arith_imm ? imm_i : rb_rdata; // Shifts use only [4:0]
			case (funct3)
				`FWRISC_F3_ADD: alu_op = (op_arith_reg && instr[30]) ? ALU_SUB : ALU_ADD;
				`FWRISC_F3_SLL: alu_op = ALU_SLL;
				`FWRISC_F3_XOR: alu_op = ALU_XOR;
				`FWRISC_F3_SR:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
				`FWRISC_F3_OR:  alu_op = ALU_OR;
				`FWRISC_F3_AND: alu_op = ALU_AND;
				default:        alu_op = ALU_ADD; // SLT/SLTU replaced by compare
			endcase
		end
	end

	// Comparator setup for branches and set-less-than
	always_comb begin
		cmp_b      = rb_rdata;
		cmp_op     = CMP_EQ;
		cmp_negate = 1'b0;
		set_less   = 1'b0;
		if (op_branch) begin
			cmp_negate = funct3[0]; // BNE, BGE, BGEU
			case (funct3[2:1])
				2'b00:   cmp_op = CMP_EQ;
				2'b10:   cmp_op = CMP_LT;
				default: cmp_op = CMP_LTU;
			endcase
		end else if ((op_arith_imm || op_arith_reg) &&
				(funct3 == `FWRISC_F3_SLT || funct3 == `FWRISC_F3_SLTU)) begin
			set_less = 1'b1;
			cmp_op   = (funct3 == `FWRISC_F3_SLTU) ? CMP_LTU : CMP_LT;
			if (op_arith_imm) begin
				cmp_b = imm_i;
			end
		end
	end

endmodule

// ==== hw/fwrisc_alu.sv ====
// Combinational ALU with branch comparator
`timescale 1ns/1ps

module fwrisc_alu (
	input  fwrisc_pkg::word_t   alu_op_a,
	input  fwrisc_pkg::word_t   alu_op_b,
	input  fwrisc_pkg::word_t   cmp_b,
	input  fwrisc_pkg::alu_op_e alu_op,
	input  fwrisc_pkg::cmp_op_e cmp_op,
	input  logic                cmp_negate,
	input  logic                set_less,
	output fwrisc_pkg::word_t   alu_out,
	output logic                branch_taken
);
	import fwrisc_pkg::*;

	word_t      arith;
	logic       cmp_res;
	logic [4:0] shamt;

	assign shamt = alu_op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:    arith = alu_op_a + alu_op_b;
			ALU_SUB:    arith = alu_op_a - alu_op_b;
			ALU_SLL:    arith = alu_op_a << shamt;
			ALU_SRL:    arith = alu_op_a >> shamt;
			ALU_SRA:    arith = word_t'($signed(alu_op_a) >>> shamt);
			ALU_XOR:    arith = alu_op_a ^ alu_op_b;
			ALU_OR:     arith = alu_op_a | alu_op_b;
			ALU_AND:    arith = alu_op_a & alu_op_b;
			ALU_PASS_B: arith = alu_op_b;
			default:    arith = alu_op_a + alu_op_b;
		endcase
	end

	// Operand A is always rs1 when a compare matters
	always_comb begin
		case (cmp_op)
			CMP_EQ:  cmp_res = (alu_op_a == cmp_b);
			CMP_LT:  cmp_res = ($signed(alu_op_a) < $signed(cmp_b));
			default: cmp_res = (alu_op_a < cmp_b); // LTU
		endcase
	end

	assign branch_taken = cmp_res ^ cmp_negate;
	assign alu_out      = set_less ? {31'b0, cmp_res} : arith; // SLT/SLTU result
endmodule

// ==== hw/fwrisc_regfile.sv ====
// Register file with two registered read ports and one write port
`timescale 1ns/1ps

module fwrisc_regfile (
	input  logic                  clock,
	input  logic                  reset,
	input  fwrisc_pkg::reg_addr_t ra_raddr,
	input  fwrisc_pkg::reg_addr_t rb_raddr,
	input  fwrisc_pkg::reg_addr_t rd_waddr,
	input  fwrisc_pkg::word_t     rd_wdata,
	input  logic                  rd_wen,
	output fwrisc_pkg::word_t     ra_rdata,
	output fwrisc_pkg::word_t     rb_rdata
);
	import fwrisc_pkg::*;

	word_t regs [2**$bits(reg_addr_t)];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
				regs[i] <= '0; // Model starts from all zeros
			end
			ra_rdata <= '0;
			rb_rdata <= '0;
		end else begin
			if (rd_wen && rd_waddr != '0) begin
				regs[rd_waddr] <= rd_wdata; // x0 never written so reads zero
			end
			ra_rdata <= regs[ra_raddr]; // Valid one cycle after address
			rb_rdata <= regs[rb_raddr];
		end
	end
endmodule

// ==== hw/fwrisc_control.sv ====
// Control FSM, PC and instruction registers, writeback select and data-bus drive
`timescale 1ns/1ps
`include "fwrisc_consts.svh"

module fwrisc_control (
	input  logic                  clock,
	input  logic                  reset,
	input  fwrisc_pkg::instr_t    idata,
	input  logic                  iready,
	input  fwrisc_pkg::word_t     drdata,
	input  logic                  dready,
	input  logic                  op_ld,
	input  logic                  op_st,
	input  logic                  op_branch,
	input  logic                  op_jal,
	input  logic                  op_jalr,
	input  fwrisc_pkg::word_t     alu_out,
	input  logic                  branch_taken,
	input  fwrisc_pkg::word_t     rb_rdata,
	output fwrisc_pkg::instr_t    instr,
	output fwrisc_pkg::pc_t       pc,
	output fwrisc_pkg::state_e    state,
	output fwrisc_pkg::word_t     iaddr,
	output logic                  ivalid,
	output fwrisc_pkg::word_t     daddr,
	output fwrisc_pkg::word_t     dwdata,
	output fwrisc_pkg::strb_t     dstrb,
	output logic                  dwrite,
	output logic                  dvalid,
	output fwrisc_pkg::reg_addr_t ra_raddr,
	output fwrisc_pkg::reg_addr_t rb_raddr,
	output fwrisc_pkg::reg_addr_t rd_waddr,
	output fwrisc_pkg::word_t     rd_wdata,
	output logic                  rd_wen
);
	import fwrisc_pkg::*;

	word_t  reset_vec;
	state_e state_next;
	pc_t    pc_plus4;
	pc_t    pc_next;
	logic   fetch_done;
	logic   mem_done;
	logic   jump;

	assign reset_vec  = `FWRISC_RESET_VECTOR;
	assign fetch_done = ivalid && iready;
	assign mem_done   = dvalid && dready;
	assign pc_plus4   = pc + 30'd1; // Word-granular PC
	assign jump       = op_jal || op_jalr || (op_branch && branch_taken);
	assign pc_next    = jump ? alu_out[31:2] : pc_plus4;

	always_comb begin
		state_next = state;
		case (state)
			FETCH:   if (fetch_done) state_next = DECODE;
			DECODE:  state_next = EXECUTE; // Register read in flight
			EXECUTE: begin
				if (op_ld) begin
					state_next = MEMR;
				end else if (op_st) begin
					state_next = MEMW;
				end else begin
					state_next = FETCH;
				end
			end
			MEMR, MEMW: if (dready) state_next = FETCH;
			default: state_next = FETCH;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= FETCH;
			pc     <= reset_vec[31:2];
			ivalid <= 1'b0;
		end else begin
			state  <= state_next;
			ivalid <= (state_next == FETCH); // Registered fetch request
			if ((state == EXECUTE && !op_ld && !op_st) || mem_done) begin
				pc <= pc_next;
			end
		end
	end

	// Instruction register
	always_ff @(posedge clock) begin
		if (fetch_done) begin
			instr <= idata;
		end
	end

	assign iaddr = {pc, 2'b00};

	// Held from DECODE on so read data stays valid through MEMR/MEMW
	assign ra_raddr = instr[19:15];
	assign rb_raddr = instr[24:20];
	assign rd_waddr = instr[11:7];

	always_comb begin
		case (state)
			EXECUTE: rd_wen = !op_ld && !op_st && !op_branch;
			MEMR:    rd_wen = dready; // Load data arrives
			default: rd_wen = 1'b0;
		endcase
	end

	always_comb begin
		if (op_jal || op_jalr) begin
			rd_wdata = {pc_plus4, 2'b00}; // Link address
		end else if (op_ld) begin
			rd_wdata = drdata;
		end else begin
			rd_wdata = alu_out;
		end
	end

	assign dvalid = (state == MEMR) || (state == MEMW);
	assign dwrite = (state == MEMW);
	assign daddr  = {alu_out[31:2], 2'b00}; // Low bits only steer lanes

	// Lane strobes and replicated store data
	always_comb begin
		dstrb  = 4'hf; // Loads read the full word
		dwdata = rb_rdata;
		if (op_st) begin
			case (instr[14:12])
				`FWRISC_F3_SB: begin
					dstrb  = 4'b0001 << alu_out[1:0];
					dwdata = {4{rb_rdata[7:0]}};
				end
				`FWRISC_F3_SH: begin
					dstrb  = 4'b0011 << {alu_out[1], 1'b0};
					dwdata = {2{rb_rdata[15:0]}};
				end
				`FWRISC_F3_SW: dstrb = 4'hf;
				default:       dstrb = 4'hf; // Reserved widths store a word
			endcase
		end
	end
endmodule

// ==== hw/fwrisc_core.sv ====
// Core top level joining control, decoder, ALU and register file
`timescale 1ns/1ps

module fwrisc_core (
	input  logic               clock,
	input  logic               reset,
	output fwrisc_pkg::word_t  iaddr,
	input  fwrisc_pkg::instr_t idata,
	output logic               ivalid,
	input  logic               iready,
	output fwrisc_pkg::word_t  daddr,
	output fwrisc_pkg::word_t  dwdata,
	input  fwrisc_pkg::word_t  drdata,
	output fwrisc_pkg::strb_t  dstrb,
	output logic               dwrite,
	output logic               dvalid,
	input  logic               dready
);
	import fwrisc_pkg::*;

	instr_t    instr;
	pc_t       pc;
	state_e    state;       // Visible to bound checkers
	logic      op_ld;
	logic      op_st;
	logic      op_branch;
	logic      op_jal;
	logic      op_jalr;
	word_t     alu_op_a;
	word_t     alu_op_b;
	alu_op_e   alu_op;
	cmp_op_e   cmp_op;
	word_t     cmp_b;
	logic      cmp_negate;
	logic      set_less;
	word_t     alu_out;
	logic      branch_taken;
	reg_addr_t ra_raddr;
	reg_addr_t rb_raddr;
	reg_addr_t rd_waddr;
	word_t     ra_rdata;
	word_t     rb_rdata;
	word_t     rd_wdata;
	logic      rd_wen;

	fwrisc_control u_control (
		.clock(clock), .reset(reset),
		.idata(idata), .iready(iready), .drdata(drdata), .dready(dready),
		.op_ld(op_ld), .op_st(op_st), .op_branch(op_branch),
		.op_jal(op_jal), .op_jalr(op_jalr),
		.alu_out(alu_out), .branch_taken(branch_taken), .rb_rdata(rb_rdata),
		.instr(instr), .pc(pc), .state(state),
		.iaddr(iaddr), .ivalid(ivalid),
		.daddr(daddr), .dwdata(dwdata), .dstrb(dstrb), .dwrite(dwrite), .dvalid(dvalid),
		.ra_raddr(ra_raddr), .rb_raddr(rb_raddr),
		.rd_waddr(rd_waddr), .rd_wdata(rd_wdata), .rd_wen(rd_wen)
	);

	fwrisc_decode u_decode (
		.instr(instr), .pc(pc), .ra_rdata(ra_rdata), .rb_rdata(rb_rdata),
		.op_ld(op_ld), .op_st(op_st), .op_branch(op_branch),
		.op_jal(op_jal), .op_jalr(op_jalr),
		.alu_op_a(alu_op_a), .alu_op_b(alu_op_b), .alu_op(alu_op),
		.cmp_op(cmp_op), .cmp_b(cmp_b), .cmp_negate(cmp_negate), .set_less(set_less)
	);

	fwrisc_alu u_alu (
		.alu_op_a(alu_op_a), .alu_op_b(alu_op_b), .cmp_b(cmp_b),
		.alu_op(alu_op), .cmp_op(cmp_op), .cmp_negate(cmp_negate), .set_less(set_less),
		.alu_out(alu_out), .branch_taken(branch_taken)
	);

	fwrisc_regfile u_regfile (
		.clock(clock), .reset(reset),
		.ra_raddr(ra_raddr), .rb_raddr(rb_raddr),
		.rd_waddr(rd_waddr), .rd_wdata(rd_wdata), .rd_wen(rd_wen),
		.ra_rdata(ra_rdata), .rb_rdata(rb_rdata)
	);
endmodule

// ==== tests/fwrisc_core_sva.sv ====
// Bus protocol assertions for the core and their bind into fwrisc_core
`timescale 1ns/1ps

module fwrisc_core_sva (
	input logic              clock,
	input logic              reset,
	input fwrisc_pkg::word_t iaddr,
	input logic              ivalid,
	input logic              iready,
	input fwrisc_pkg::word_t daddr,
	input fwrisc_pkg::word_t dwdata,
	input fwrisc_pkg::strb_t dstrb,
	input logic              dwrite,
	input logic              dvalid,
	input logic              dready
);
	int unsigned assert_errors = 0; // Failure count, read by the testbench

	// One bus at a time
	bus_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid))
		else begin
			$error("ivalid and dvalid high together");
			assert_errors++;
		end

	fetch_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else begin
			$error("iaddr moved during a fetch stall");
			assert_errors++;
		end

	// Request fields frozen until dready
	data_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) &&
			$stable(dstrb) && $stable(dwrite))
		else begin
			$error("data bus request changed during a stall");
			assert_errors++;
		end

	reset_idle: assert property (@(posedge clock) reset |=> !ivalid && !dvalid)
		else begin
			$error("bus request active during reset");
			assert_errors++;
		end
endmodule

bind fwrisc_core fwrisc_core_sva sva_inst (
	.clock(clock),
	.reset(reset),
	.iaddr(iaddr),
	.ivalid(ivalid),
	.iready(iready),
	.daddr(daddr),
	.dwdata(dwdata),
	.dstrb(dstrb),
	.dwrite(dwrite),
	.dvalid(dvalid),
	.dready(dready)
);

// ==== tests/fwrisc_core_tb.sv ====
// Core testbench with random program, bus memories, reference ISA model, checks and watchdog
`timescale 1ns/1ps
`include "fwrisc_consts.svh"

module fwrisc_core_tb;
	import fwrisc_pkg::*;

	localparam int NRAND      = 60;             // Random part of the program
	localparam int NPROG      = NRAND + 32;     // Plus 31 SW and the closing JAL
	localparam int NWORDS     = 512;            // Data space 0 to 0x7ff
	localparam int TIMEOUT_NS = 8 * (5 + NPROG * 20);

	logic   clock;
	logic   reset;
	word_t  iaddr;
	instr_t idata;
	logic   ivalid;
	logic   iready;
	word_t  daddr;
	word_t  dwdata;
	word_t  drdata;
	strb_t  dstrb;
	logic   dwrite;
	logic   dvalid;
	logic   dready;

	integer seed = 19;
	int     nwrites = 0;
	int     total_writes = 0;

	// Program as generated, fields before encoding
	logic [6:0] p_op  [NPROG];
	logic [2:0] p_f3  [NPROG];
	logic       p_alt [NPROG]; // instr[30]
	reg_addr_t  p_rd  [NPROG];
	reg_addr_t  p_rs1 [NPROG];
	reg_addr_t  p_rs2 [NPROG];
	word_t      p_imm [NPROG];
	instr_t     imem  [NPROG];

	word_t mregs [32];
	word_t mdmem [NWORDS]; // Model view of data memory
	word_t bmem  [NWORDS]; // Bus-side memory seen by the DUT
	word_t exp_waddr [$];
	word_t exp_wdata [$];
	word_t exp_wstrb [$];
	word_t exp_raddr [$];
	word_t exp_rdata [$];

	fwrisc_core fwrisc_core_inst (
		.clock(clock), .reset(reset),
		.iaddr(iaddr), .idata(idata), .ivalid(ivalid), .iready(iready),
		.daddr(daddr), .dwdata(dwdata), .drdata(drdata), .dstrb(dstrb),
		.dwrite(dwrite), .dvalid(dvalid), .dready(dready)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Forward jump length in instructions, never past the random block
	function automatic int forward_steps(input int k);
		int n;
		n = 1 + rnd(4);
		if (k + n > NRAND) begin
			n = NRAND - k;
		end
		return n;
	endfunction

	function automatic word_t merge_lanes(input word_t old, input word_t data, input strb_t strb);
		word_t w;
		w = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				w[8*i +: 8] = data[8*i +: 8];
			end
		end
		return w;
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			stop_on_failure("DUT response differs from the reference model");
		end
	endtask

	task automatic place(input int k, input logic [6:0] op, input logic [2:0] f3,
			input logic alt, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input word_t imm);
		p_op[k]  = op;
		p_f3[k]  = f3;
		p_alt[k] = alt;
		p_rd[k]  = rd;
		p_rs1[k] = rs1;
		p_rs2[k] = rs2;
		p_imm[k] = imm;
	endtask

	// Instruction word from the generated fields, per the RV32I formats
	function automatic instr_t encode(input int k);
		word_t  im;
		instr_t ins;
		im  = p_imm[k];
		ins = {7'b0, p_rs2[k], p_rs1[k], p_f3[k], p_rd[k], p_op[k]};
		case (p_op[k])
			`FWRISC_OPC_OP: ins[31:25] = {1'b0, p_alt[k], 5'b0};
			`FWRISC_OPC_OP_IMM, `FWRISC_OPC_LOAD, `FWRISC_OPC_JALR: ins[31:20] = im[11:0];
			`FWRISC_OPC_STORE: begin
				ins[31:25] = im[11:5];
				ins[11:7]  = im[4:0];
			end
			`FWRISC_OPC_BRANCH: begin
				ins[31:25] = {im[12], im[10:5]};
				ins[11:7]  = {im[4:1], im[11]};
			end
			`FWRISC_OPC_LUI, `FWRISC_OPC_AUIPC: ins[31:12] = im[31:12];
			`FWRISC_OPC_JAL: ins[31:12] = {im[20], im[10:1], im[11], im[19:12]};
			default: ins = ins;
		endcase
		return ins;
	endfunction

	task automatic build_program();
		int        k;
		int        kind;
		int        f3;
		word_t     imm;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rt;
		k = 0;
		while (k < NRAND) begin
			kind = rnd(16);
			f3   = rnd(8);
			imm  = word_t'(rnd(4096) - 2048);
			rd   = reg_addr_t'(rnd(32));
			rs1  = reg_addr_t'(rnd(32));
			rs2  = reg_addr_t'(rnd(32));
			if (kind < 5 || (kind == 15 && k == NRAND - 1)) begin
				if (f3 == 1 || f3 == 5) begin // Shift amount, SRAI flag in bit 10
					imm = {21'b0, (f3 == 5) && (rnd(2) == 1), 5'b0, 5'(rnd(32))};
				end
				place(k, `FWRISC_OPC_OP_IMM, 3'(f3), imm[10], rd, rs1, rs2, imm);
			end else if (kind < 9) begin
				place(k, `FWRISC_OPC_OP, 3'(f3), (f3 == 0 || f3 == 5) && (rnd(2) == 1),
					rd, rs1, rs2, '0);
			end else if (kind < 11) begin
				imm = {20'(rnd(1 << 20)), 12'b0};
				place(k, (kind == 9) ? `FWRISC_OPC_LUI : `FWRISC_OPC_AUIPC, 3'b000, 1'b0,
					rd, '0, '0, imm);
			end else if (kind == 11) begin
				place(k, `FWRISC_OPC_LOAD, 3'b010, 1'b0, rd, '0, '0, word_t'(rnd(1024)));
			end else if (kind == 12) begin
				place(k, `FWRISC_OPC_STORE, 3'(rnd(3)), 1'b0, '0, '0, rs2, word_t'(rnd(1024)));
			end else if (kind == 13) begin
				f3 = rnd(6);
				if (f3 >= 2) begin
					f3 = f3 + 2; // BLT and up
				end
				place(k, `FWRISC_OPC_BRANCH, 3'(f3), 1'b0, '0, rs1, rs2,
					word_t'(4 * forward_steps(k)));
			end else if (kind == 14) begin
				place(k, `FWRISC_OPC_JAL, 3'b000, 1'b0, rd, '0, '0, word_t'(4 * forward_steps(k)));
			end else begin
				rt = reg_addr_t'(1 + rnd(31)); // AUIPC gives JALR its base
				place(k, `FWRISC_OPC_AUIPC, 3'b000, 1'b0, rt, '0, '0, '0);
				k++;
				place(k, `FWRISC_OPC_JALR, 3'b000, 1'b0, rd, rt, '0,
					word_t'(4 * (1 + forward_steps(k))));
			end
			k++;
		end
		for (int i = 1; i < 32; i++) begin
			place(NRAND + i - 1, `FWRISC_OPC_STORE, `FWRISC_F3_SW, 1'b0, '0, '0,
				reg_addr_t'(i), word_t'(32'h400 + 4 * (i - 1)));
		end
		place(NPROG - 1, `FWRISC_OPC_JAL, 3'b000, 1'b0, '0, '0, '0, '0); // Spin
		for (int i = 0; i < NPROG; i++) begin
			imem[i] = encode(i);
		end
	endtask

	function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	// Reference run of the whole program, fills the expected bus queues
	task automatic run_model();
		int    k;
		int    steps;
		word_t pcw;
		word_t a;
		word_t b;
		word_t im;
		word_t res;
		word_t tgt;
		word_t addr;
		word_t sdata;
		strb_t sstrb;
		logic  wr;
		logic  taken;
		k     = 0;
		steps = 0;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		while (k < NPROG - 1 && steps < 4 * NPROG) begin
			pcw   = `FWRISC_RESET_VECTOR + word_t'(4 * k);
			a     = mregs[p_rs1[k]];
			b     = mregs[p_rs2[k]];
			im    = p_imm[k];
			tgt   = pcw + 32'd4;
			res   = pcw + 32'd4; // Link value
			addr  = a + im;
			wr    = 1'b1;
			taken = 1'b0;
			case (p_op[k])
				`FWRISC_OPC_OP_IMM: res = alu_model(p_f3[k], p_alt[k] && p_f3[k] == 3'd5, a, im);
				`FWRISC_OPC_OP:     res = alu_model(p_f3[k], p_alt[k], a, b);
				`FWRISC_OPC_LUI:    res = im;
				`FWRISC_OPC_AUIPC:  res = pcw + im;
				`FWRISC_OPC_JAL:    tgt = pcw + im;
				`FWRISC_OPC_JALR:   tgt = (a + im) & ~32'd1;
				`FWRISC_OPC_BRANCH: begin
					wr = 1'b0;
					case (p_f3[k])
						3'd0:    taken = (a == b);
						3'd1:    taken = (a != b);
						3'd4:    taken = ($signed(a) < $signed(b));
						3'd5:    taken = ($signed(a) >= $signed(b));
						3'd6:    taken = (a < b);
						default: taken = (a >= b);
					endcase
					if (taken) begin
						tgt = pcw + im;
					end
				end
				`FWRISC_OPC_LOAD: begin
					res = mdmem[addr[10:2]];
					exp_raddr.push_back({addr[31:2], 2'b00});
					exp_rdata.push_back(res);
				end
				`FWRISC_OPC_STORE: begin
					wr = 1'b0;
					case (p_f3[k])
						`FWRISC_F3_SB: begin
							sstrb = 4'b0001 << addr[1:0];
							sdata = {4{b[7:0]}};
						end
						`FWRISC_F3_SH: begin
							sstrb = addr[1] ? 4'b1100 : 4'b0011;
							sdata = {2{b[15:0]}};
						end
						default: begin
							sstrb = 4'hf;
							sdata = b;
						end
					endcase
					mdmem[addr[10:2]] = merge_lanes(mdmem[addr[10:2]], sdata, sstrb);
					exp_waddr.push_back({addr[31:2], 2'b00});
					exp_wdata.push_back(sdata);
					exp_wstrb.push_back({28'b0, sstrb});
				end
				default: wr = 1'b0;
			endcase
			if (wr && p_rd[k] != '0) begin
				mregs[p_rd[k]] = res;
			end
			k = int'((tgt - `FWRISC_RESET_VECTOR) >> 2);
			steps++;
		end
		total_writes = exp_waddr.size();
	endtask

	// One completed data transfer, called in the cycle before the dready edge
	task automatic serve_data();
		if (dwrite) begin
			if (exp_waddr.size() == 0) begin
				stop_on_failure("data write beyond the expected store sequence");
			end else begin
				check_value("store address", exp_waddr.pop_front(), daddr);
				check_value("store data", exp_wdata.pop_front(), dwdata);
				check_value("store strobe", exp_wstrb.pop_front(), {28'b0, dstrb});
				bmem[daddr[10:2]] = merge_lanes(bmem[daddr[10:2]], dwdata, dstrb);
				nwrites++;
			end
		end else begin
			if (exp_raddr.size() == 0) begin
				stop_on_failure("data read beyond the expected load sequence");
			end else begin
				check_value("load address", exp_raddr.pop_front(), daddr);
				check_value("load data", exp_rdata.pop_front(), drdata);
			end
		end
	endtask

	// Bus slaves, inputs change on the falling edge only
	always @(negedge clock) begin
		word_t idx;
		iready = (rnd(4) != 0); // Stall about one cycle in four
		dready = (rnd(4) != 0);
		if (ivalid) begin
			idx = (iaddr - `FWRISC_RESET_VECTOR) >> 2;
			if (idx >= NPROG) begin
				stop_on_failure("instruction fetch outside the program");
			end else begin
				idata = imem[idx];
			end
		end
		if (dvalid) begin
			drdata = bmem[daddr[10:2]];
			if (dready) begin
				serve_data();
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		stop_on_failure("watchdog expired before the expected stores completed");
	end

	initial begin
		reset  = 1'b1;
		iready = 1'b0;
		dready = 1'b0;
		idata  = '0;
		drdata = '0;
		build_program();
		for (int i = 0; i < NWORDS; i++) begin
			mdmem[i] = $random(seed);
			bmem[i]  = mdmem[i];
		end
		run_model();
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (nwrites < total_writes) begin
			@(posedge clock);
		end
		repeat (20) @(posedge clock); // Core spins on the closing JAL
		check_value("loads left over", 32'd0, word_t'(exp_raddr.size()));
		if (fwrisc_core_inst.sva_inst.assert_errors == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "bus protocol assertions failed");
		end
	end
endmodule

// ==== fwrisc_core.f ====
+incdir+hw
hw/fwrisc_pkg.sv
hw/fwrisc_decode.sv
hw/fwrisc_alu.sv
hw/fwrisc_regfile.sv
hw/fwrisc_control.sv
hw/fwrisc_core.sv
tests/fwrisc_core_sva.sv
tests/fwrisc_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fwrisc_core.f \
	--top-module fwrisc_core_tb -o fwrisc_core_sim

result=$(./obj_dir/fwrisc_core_sim 2>&1) || true
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "Finished with no errors"
